//--- verif/core_top_tests.txt
# op and arguments; read takes slot id and table word in hex, the rest are decimal
# key | dl hold | read id word | done hold | pix count active | pixr count | wait cycles
wait 4
pix 40 30
key
wait 10
dl 50
wait 3
read 0005 00001234
read 03ff deadbeef
read 1200 0000c0de
wait 2
done 12
wait 6
done 8
pixr 64
pix 20 0
pix 24 24
key
dl 0
pix 16 16
read 0000 ffffffff
read 8001 00000400
pixr 100
done 20
wait 5

//--- compile.f
source/core_pkg.sv
source/pixel_if.sv
source/core_reset_ctrl.sv
source/dataslot_seq.sv
source/video_out.sv
source/core_top.sv
verif/core_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the core_top testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module core_top_tb -f compile.f -o core_top_sim

# a failing run exits nonzero, the pass line decides the result
sim_out=$(./obj_dir/core_top_sim) || true
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qF '** PASS **'

//--- verif/core_top_tb.sv
/*
 * testbench for the glue logic top level
 * replays the operations of the tests file and checks reset control,
 * data-slot sequencing and the video stage against reference rules
 */

`timescale 1ns/1ps
`default_nettype none

module core_top_tb;

  logic                  clk_sys;
  logic                  rst_n;
  logic                  key_start;
  logic                  dl_request;
  logic                  dl_all_complete;
  logic                  core_read_req;
  core_pkg::slot_id_t    slot_id;
  core_pkg::word_t       table_q;
  logic                  slot_done;
  core_pkg::rgb565_t     rgb565;
  logic                  hsync;
  logic                  vsync;
  logic                  de;
  logic                  core_reset;
  logic                  target_read;
  core_pkg::table_addr_t table_addr;
  core_pkg::word_t       file_size;
  logic                  slot_complete;
  core_pkg::rgb888_t     video_rgb;
  logic                  video_hs;
  logic                  video_vs;
  logic                  video_de;

  core_top core_top_inst (.*);

  // parsed operations
  string       op_q[$];
  logic [31:0] arg_a_q[$];
  logic [31:0] arg_b_q[$];
  int          cycle_limit = 0;
  int          cycle_count = 0;

  // pixel inputs of the last two cycles
  core_pkg::rgb565_t prev_rgb = '0;
  logic              prev_de = 1'b0;
  logic              prev2_de = 1'b0;
  logic              prev_hs = 1'b0;
  logic              prev_vs = 1'b0;

  always #50 clk_sys = ~clk_sys;

  ////////////////////////////////////////////////////////////////////////////
  // failure handling and checks

  task automatic stop_with_failure();
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, expected);
      stop_with_failure();
    end
  endtask

  // runaway guard
  always @(posedge clk_sys) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      stop_with_failure();
    end
  end

  // channel moved to the top of 8 bits and its top bits refill the bottom
  function automatic core_pkg::rgb888_t expand_rgb565(input core_pkg::rgb565_t pix);
    logic [7:0] red8;
    logic [7:0] grn8;
    logic [7:0] blu8;
    red8 = (8'(pix[15:11]) << 3) | (8'(pix[15:11]) >> 2);
    grn8 = (8'(pix[10:5]) << 2) | (8'(pix[10:5]) >> 4);
    blu8 = (8'(pix[4:0]) << 3) | (8'(pix[4:0]) >> 2);
    return {red8, grn8, blu8};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // tests file

  task automatic load_tests();
    int          fd;
    int          got;
    int          requested;
    int          key_count;
    string       line;
    string       op;
    logic [31:0] arg_a;
    logic [31:0] arg_b;
    requested = 0;
    key_count = 0;
    fd = $fopen("verif/core_top_tests.txt", "r");
    if (fd == 0) begin
      $display("Error: the tests file verif/core_top_tests.txt could not be opened");
      stop_with_failure();
    end
    while (!$feof(fd)) begin
      line = "";
      got = $fgets(line, fd);
      // blank lines and comments
      if (got == 0 || line.len() < 2 || line.getc(0) == "#") continue;
      arg_a = '0;
      arg_b = '0;
      got = $sscanf(line, "%s", op);
      if (op == "read") got = $sscanf(line, "%s %h %h", op, arg_a, arg_b);
      else got = $sscanf(line, "%s %d %d", op, arg_a, arg_b);
      if (op == "key") key_count++;
      else if (op == "read") requested += core_pkg::READ_STRETCH_CYCLES;
      else if (op == "dl" || op == "done" || op == "pix" || op == "pixr" || op == "wait")
        requested += int'(arg_a);
      else begin
        $display("Error: unknown operation '%s' in the tests file", op);
        stop_with_failure();
      end
      op_q.push_back(op);
      arg_a_q.push_back(arg_a);
      arg_b_q.push_back(arg_b);
    end
    $fclose(fd);
    // per-line slack covers edge detectors and syncs
    cycle_limit = requested + core_pkg::RESET_HOLD_CYCLES * key_count + 20 * op_q.size() + 100;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // operations

  task automatic press_key();
    int rise_wait;
    int high_count;
    rise_wait = 0;
    high_count = 0;
    @(negedge clk_sys);
    check_value("core_reset", core_reset, 0);
    key_start = 1'b1;
    while (!core_reset && rise_wait < 5) begin
      @(negedge clk_sys);
      rise_wait++;
    end
    if (!core_reset) begin
      $display("Error: core_reset did not rise within 5 cycles of the key press");
      stop_with_failure();
    end
    key_start = 1'b0;
    while (core_reset && high_count <= core_pkg::RESET_HOLD_CYCLES) begin
      high_count++;
      @(negedge clk_sys);
    end
    check_value("core_reset high cycles", high_count, core_pkg::RESET_HOLD_CYCLES);
  endtask

  task automatic run_download(input int hold);
    @(negedge clk_sys);
    check_value("core_reset", core_reset, 0);
    dl_request = 1'b1;
    @(negedge clk_sys);
    dl_request = 1'b0;
    check_value("core_reset", core_reset, 1);
    repeat (hold) begin
      @(negedge clk_sys);
      check_value("core_reset", core_reset, 1);
    end
    dl_all_complete = 1'b1;
    @(negedge clk_sys);
    dl_all_complete = 1'b0;
    check_value("core_reset", core_reset, 0);
  endtask

  task automatic read_slot(input logic [31:0] id, input logic [31:0] word);
    int high_count;
    high_count = 0;
    @(negedge clk_sys);
    check_value("target_read", target_read, 0);
    slot_id = core_pkg::slot_id_t'(id);
    table_q = word;
    core_read_req = 1'b1;
    @(negedge clk_sys);
    core_read_req = 1'b0;
    if (!target_read) begin
      $display("Error: target_read strobe missing after the read request");
      stop_with_failure();
    end
    while (target_read && high_count <= core_pkg::READ_STRETCH_CYCLES) begin
      high_count++;
      @(negedge clk_sys);
    end
    check_value("target_read high cycles", high_count, core_pkg::READ_STRETCH_CYCLES);
    // size entry at 2 * id + 1 wrapped to ten bits
    check_value("table_addr", table_addr, ((id & 32'h3ff) * 2 + 1) & 32'h3ff);
    check_value("file_size", file_size, word);
  endtask

  task automatic finish_slot(input int hold);
    int pulse_count;
    int pulse_at;
    pulse_count = 0;
    pulse_at = 0;
    @(negedge clk_sys);
    slot_done = 1'b1;
    for (int step = 1; step <= hold; step++) begin
      @(negedge clk_sys);
      if (slot_complete) begin
        pulse_count++;
        pulse_at = step;
      end
    end
    slot_done = 1'b0;
    // let the synchronizer drain
    repeat (core_pkg::SYNC_STAGES + 2) begin
      @(negedge clk_sys);
      if (slot_complete) pulse_count++;
    end
    check_value("slot_complete pulses", pulse_count, 1);
    check_value("slot_complete delay", pulse_at, core_pkg::SYNC_STAGES + 1);
  endtask

  task automatic run_pixels(input int count, input int active, input logic random_de);
    logic [31:0] pick;
    for (int step = 0; step < count + 2; step++) begin
      @(negedge clk_sys);
      pick = $urandom();
      // two idle cycles close every run
      rgb565 = (step < count) ? core_pkg::rgb565_t'($urandom()) : '0;
      hsync = (step < count) ? pick[0] : 1'b0;
      vsync = (step < count) ? pick[1] : 1'b0;
      de = (step < count) ? (random_de ? pick[2] : (step < active)) : 1'b0;
      #1;
      check_value("video_rgb", video_rgb, prev_de ? expand_rgb565(prev_rgb) : '0);
      check_value("video_hs", video_hs, prev_hs);
      check_value("video_vs", video_vs, prev_vs);
      check_value("video_de", video_de, de | prev_de | prev2_de);
      prev2_de = prev_de;
      prev_de = de;
      prev_rgb = rgb565;
      prev_hs = hsync;
      prev_vs = vsync;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    clk_sys = 1'b0;
    rst_n = 1'b0;
    key_start = 1'b0;
    dl_request = 1'b0;
    dl_all_complete = 1'b0;
    core_read_req = 1'b0;
    slot_id = '0;
    table_q = '0;
    slot_done = 1'b0;
    rgb565 = '0;
    hsync = 1'b0;
    vsync = 1'b0;
    de = 1'b0;
    void'($urandom(63769));
    load_tests();
    repeat (8) @(negedge clk_sys);
    rst_n = 1'b1;
    @(negedge clk_sys);
    check_value("core_reset", core_reset, 0);
    check_value("target_read", target_read, 0);
    check_value("slot_complete", slot_complete, 0);
    check_value("video_de", video_de, 0);
    check_value("video_rgb", video_rgb, 0);
    check_value("video_hs", video_hs, 0);
    check_value("video_vs", video_vs, 0);
    for (int i = 0; i < op_q.size(); i++) begin
      if (op_q[i] == "key") press_key();
      else if (op_q[i] == "dl") run_download(int'(arg_a_q[i]));
      else if (op_q[i] == "read") read_slot(arg_a_q[i], arg_b_q[i]);
      else if (op_q[i] == "done") finish_slot(int'(arg_a_q[i]));
      else if (op_q[i] == "pix") run_pixels(int'(arg_a_q[i]), int'(arg_b_q[i]), 1'b0);
      else if (op_q[i] == "pixr") run_pixels(int'(arg_a_q[i]), 0, 1'b1);
      else repeat (int'(arg_a_q[i])) @(negedge clk_sys);
    end
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/core_top.sv
/*
 * glue logic top level around the soft SoC
 * core reset control, data-slot sequencing and the video output stage,
 * all on clk_sys
 */

`timescale 1ns/1ps
`default_nettype none

module core_top (
  input  wire                    clk_sys,
  input  wire                    rst_n,

  // reset sources
  input  wire                    key_start,
  input  wire                    dl_request,
  input  wire                    dl_all_complete,

  // data slots
  input  wire                    core_read_req,
  input  core_pkg::slot_id_t     slot_id,
  input  core_pkg::word_t        table_q,
  input  wire                    slot_done,

  // pixels from the SoC
  input  core_pkg::rgb565_t      rgb565,
  input  wire                    hsync,
  input  wire                    vsync,
  input  wire                    de,

  output logic                   core_reset,
  output logic                   target_read,
  output core_pkg::table_addr_t  table_addr,
  output core_pkg::word_t        file_size,
  output logic                   slot_complete,

  // to the scaler
  output core_pkg::rgb888_t      video_rgb,
  output logic                   video_hs,
  output logic                   video_vs,
  output logic                   video_de
);

  ////////////////////////////////////////////////////////////////////////////
  // reset control

  core_reset_ctrl core_reset_ctrl_inst (
    .clk_sys         (clk_sys),
    .rst_n           (rst_n),
    .key_start       (key_start),
    .dl_request      (dl_request),
    .dl_all_complete (dl_all_complete),
    .core_reset      (core_reset)
  );

  ////////////////////////////////////////////////////////////////////////////
  // data slots

  dataslot_seq dataslot_seq_inst (
    .clk_sys       (clk_sys),
    .rst_n         (rst_n),
    .core_read_req (core_read_req),
    .slot_id       (slot_id),
    .table_q       (table_q),
    .slot_done     (slot_done),
    .target_read   (target_read),
    .table_addr    (table_addr),
    .file_size     (file_size),
    .slot_complete (slot_complete)
  );

  ////////////////////////////////////////////////////////////////////////////
  // video

  // bundle the loose pixel pins
  pixel_if pix ();

  assign pix.rgb565 = rgb565;
  assign pix.hsync  = hsync;
  assign pix.vsync  = vsync;
  assign pix.de     = de;

  video_out video_out_inst (
    .clk_sys   (clk_sys),
    .rst_n     (rst_n),
    .pix       (pix),
    .video_rgb (video_rgb),
    .video_hs  (video_hs),
    .video_vs  (video_vs),
    .video_de  (video_de)
  );

endmodule

`default_nettype wire

//--- source/video_out.sv
/*
 * video output stage
 * RGB565 to RGB888 by bit replication, sync delayed one cycle and
 * data-enable widened so the scaler gets a trailing black column
 */

`timescale 1ns/1ps
`default_nettype none

module video_out (
  input  wire                clk_sys,
  input  wire                rst_n,
  pixel_if.sink              pix,
  output core_pkg::rgb888_t  video_rgb,
  output logic               video_hs,
  output logic               video_vs,
  output logic               video_de
);

  ////////////////////////////////////////////////////////////////////////////
  // colour expansion

  logic [4:0]        red5;
  logic [5:0]        grn6;
  logic [4:0]        blu5;
  core_pkg::rgb888_t rgb_expanded;

  assign red5 = pix.rgb565[15:11];
  assign grn6 = pix.rgb565[10:5];
  assign blu5 = pix.rgb565[4:0];

  // top bits refill the low end so full white stays full white
  assign rgb_expanded = {red5, red5[4:2], grn6, grn6[5:4], blu5, blu5[4:2]};

  ////////////////////////////////////////////////////////////////////////////
  // pipeline

  core_pkg::rgb888_t rgb_q;
  logic              de_d1;
  logic              de_d2;

  // expanded pixel lines up with de_d1
  always_ff @(posedge clk_sys) begin
    rgb_q <= rgb_expanded;
  end

  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      de_d1    <= 1'b0;
      de_d2    <= 1'b0;
      video_hs <= 1'b0;
      video_vs <= 1'b0;
    end else begin
      de_d1    <= pix.de;
      de_d2    <= de_d1;
      video_hs <= pix.hsync;
      video_vs <= pix.vsync;
    end
  end

  // black outside the delayed active window
  assign video_rgb = de_d1 ? rgb_q : '0;

  // two extra cycles at the end of each run
  assign video_de = pix.de | de_d1 | de_d2;

endmodule

`default_nettype wire

//--- source/dataslot_seq.sv
/*
 * data-slot read sequencing
 * stretches core read requests into a host strobe, looks up the file
 * size for the slot and turns the host done level into a pulse
 */

`timescale 1ns/1ps
`default_nettype none

module dataslot_seq (
  input  wire                     clk_sys,
  input  wire                     rst_n,
  input  wire                     core_read_req,
  input  core_pkg::slot_id_t      slot_id,
  input  core_pkg::word_t         table_q,
  input  wire                     slot_done,
  output logic                    target_read,
  output core_pkg::table_addr_t   table_addr,
  output core_pkg::word_t         file_size,
  output logic                    slot_complete
);

  localparam int STRETCH_W = $clog2(core_pkg::READ_STRETCH_CYCLES + 1);

  ////////////////////////////////////////////////////////////////////////////
  // read strobe stretcher

  logic                 req_prev;
  logic                 req_rise;
  logic [STRETCH_W-1:0] stretch_count;

  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      req_prev <= 1'b0;
    end else begin
      req_prev <= core_read_req;
    end
  end

  assign req_rise = core_read_req & ~req_prev;

  // new edge mid-strobe restarts the count
  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      stretch_count <= '0;
    end else if (req_rise) begin
      stretch_count <= STRETCH_W'(core_pkg::READ_STRETCH_CYCLES);
    end else if (stretch_count != '0) begin
      stretch_count <= stretch_count - 1'b1;
    end
  end

  // host samples this, so it must outlast the request
  assign target_read = (stretch_count != '0);

  ////////////////////////////////////////////////////////////////////////////
  // file size lookup

  // size word sits at odd entries, 2*id + 1
  always_ff @(posedge clk_sys) begin
    table_addr <= (slot_id[core_pkg::TABLE_ADDR_W-1:0] << 1) + core_pkg::table_addr_t'(1);
    file_size  <= table_q;
  end

  ////////////////////////////////////////////////////////////////////////////
  // done synchronizer and complete pulse

  logic [core_pkg::SYNC_STAGES-1:0] done_sync;
  logic                             done_prev;

  // done level comes from the host domain
  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      done_sync     <= '0;
      done_prev     <= 1'b0;
      slot_complete <= 1'b0;
    end else begin
      done_sync     <= {done_sync[core_pkg::SYNC_STAGES-2:0], slot_done};
      done_prev     <= done_sync[core_pkg::SYNC_STAGES-1];
      // rising edge only, held level stays quiet
      slot_complete <= done_sync[core_pkg::SYNC_STAGES-1] & ~done_prev;
    end
  end

endmodule

`default_nettype wire

//--- source/core_reset_ctrl.sv
/*
 * core reset control
 * start key press holds the core in reset for a fixed count,
 * a data download holds it from write request to all-complete
 */

`timescale 1ns/1ps
`default_nettype none

module core_reset_ctrl (
  input  wire  clk_sys,
  input  wire  rst_n,
  input  wire  key_start,
  input  wire  dl_request,
  input  wire  dl_all_complete,
  output logic core_reset
);

  ////////////////////////////////////////////////////////////////////////////
  // key synchronizer and press edge

  // key comes from the controller side, not clk_sys
  logic [core_pkg::SYNC_STAGES-1:0] key_sync;
  logic                             key_prev;
  logic                             key_press;

  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      key_sync <= '0;
      key_prev <= 1'b0;
    end else begin
      key_sync <= {key_sync[core_pkg::SYNC_STAGES-2:0], key_start};
      key_prev <= key_sync[core_pkg::SYNC_STAGES-1];
    end
  end

  // one cycle on the press only
  assign key_press = key_sync[core_pkg::SYNC_STAGES-1] & ~key_prev;

  ////////////////////////////////////////////////////////////////////////////
  // hold timer

  core_pkg::reset_count_t hold_count;

  // a press while counting reloads
  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      hold_count <= '0;
    end else if (key_press) begin
      hold_count <= core_pkg::reset_count_t'(core_pkg::RESET_HOLD_CYCLES);
    end else if (hold_count != '0) begin
      hold_count <= hold_count - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // download level

  logic dl_active;

  // set on request, cleared when every slot is in
  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      dl_active <= 1'b0;
    end else if (dl_request) begin
      dl_active <= 1'b1;
    end else if (dl_all_complete) begin
      dl_active <= 1'b0;
    end
  end

  // either source keeps the core down
  assign core_reset = dl_active | (hold_count != '0);

endmodule

`default_nettype wire

//--- source/pixel_if.sv
/*
 * pixel bundle from the SoC video generator
 * one RGB565 pixel with its sync and data-enable levels
 */

`timescale 1ns/1ps
`default_nettype none

interface pixel_if;

  // 5-6-5 pixel, r in the top bits
  core_pkg::rgb565_t rgb565;
  // sync levels
  logic hsync;
  logic vsync;
  // active video
  logic de;

  // video output stage only reads the bundle
  modport sink (
    input rgb565,
    input hsync,
    input vsync,
    input de
  );

endinterface

`default_nettype wire

//--- source/core_pkg.sv
/*
 * core glue package
 * widths, vector typedefs and timing constants shared by the reset,
 * data-slot and video blocks around the soft SoC
 */

`default_nettype none

package core_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths

  // pixel formats
  localparam int RGB565_W = 16;
  localparam int RGB888_W = 24;

  // host bus side
  localparam int WORD_W       = 32;
  localparam int SLOT_ID_W    = 16;
  localparam int TABLE_ADDR_W = 10;

  // reset hold timer
  localparam int RESET_COUNT_W = 16;

  ////////////////////////////////////////////////////////////////////////////
  // types

  typedef logic [RGB565_W-1:0]      rgb565_t;
  typedef logic [RGB888_W-1:0]      rgb888_t;
  typedef logic [WORD_W-1:0]        word_t;
  typedef logic [SLOT_ID_W-1:0]     slot_id_t;
  typedef logic [TABLE_ADDR_W-1:0]  table_addr_t;
  typedef logic [RESET_COUNT_W-1:0] reset_count_t;

  ////////////////////////////////////////////////////////////////////////////
  // timing

  // core held in reset this long after a start press
  localparam int RESET_HOLD_CYCLES = 1024;
  // host read strobe length
  localparam int READ_STRETCH_CYCLES = 7;
  // flops per synchronizer
  localparam int SYNC_STAGES = 3;

endpackage

`default_nettype wire
